/* list.f */
hw/avmm_cmd_pkg.sv
hw/avmm_rsp_pkg.sv
hw/avmm_cmd_builder.sv
hw/avmm_rsp_packer.sv
hw/avmm_rsp_fifo.sv
hw/avmm_rsp_serializer.sv
hw/avmm_transfer.sv
tests/tb_avmm_transfer.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_avmm_transfer
FILELIST   := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_avmm_transfer.sv */
// Random-stimulus testbench for the AVMM transfer block.
// Encodes command frames, models both targets and decodes the serial response line.
`timescale 1ns/100ps
`default_nettype none

module tb_avmm_transfer;
  import avmm_cmd_pkg::*;
  import avmm_rsp_pkg::*;

  logic       clk;
  logic       rst_n;
  logic [1:0] data_in;
  logic       hip_sel;
  pld_rsp_t   pld_rsp;
  ehip_rsp_t  ehip_rsp;
  pld_req_t   pld_req;
  ehip_req_t  ehip_req;
  logic       data_out;
  logic       ungate;
  logic       error;

  logic [31:0] rng;
  int          checks;
  int          errors;
  int          err_pulses;
  int          rx_cnt;
  int          rx_idx;
  logic [15:0] rx_bits;
  logic        hung;
  logic        ovf_mode;
  rsp_word_t   ovf_word;
  rsp_word_t   exp_q[$];
  pld_req_t    pld_seen[$];
  ehip_req_t   ehip_seen[$];

  avmm_transfer #(
    .FIFO_AWIDTH (4)
  ) avmm_transfer_i (
    .avmm_clock_avmm_clk      (clk),
    .avmm_reset_avmm_rst_n    (rst_n),
    .aib_hssi_avmm_data_in    (data_in),
    .r_avmm2_hip_sel          (hip_sel),
    .pld_rsp                  (pld_rsp),
    .ehip_rsp                 (ehip_rsp),
    .pld_req                  (pld_req),
    .ehip_req                 (ehip_req),
    .aib_hssi_avmm_data_out   (data_out),
    .avmm_transfer_dcg_ungate (ungate),
    .avmm_transfer_error      (error)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Frame word in the PLD or EHIP layout, top bit makes it odd parity
  function automatic logic [31:0] make_cmd(input logic sel, input logic rd, input logic wr,
                                           input logic [20:0] addr, input logic [7:0] dat);
    logic [30:0] body;
    if (sel) body = {rd, wr, addr, dat};
    else     body = {12'd0, dat, addr[8:0], rd, wr};
    return {~^body, body};
  endfunction

  // Response layout, bit 0 first, bit 14 gives even parity
  function automatic rsp_word_t exp_word(input logic st, input logic [7:0] d,
                                         input logic v, input logic [2:0] rsv);
    logic [15:0] w;
    w     = {1'b1, 1'b0, rsv, v, d, st, 1'b1};
    w[14] = ^w;                        // Even over the other 15 bits
    return w;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_pld_req(input pld_req_t got, input pld_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: PLD request %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_ehip_req(input ehip_req_t got, input ehip_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: EHIP request %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_rsp(input rsp_word_t got, input rsp_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: response word %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    hung = 1'b1;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  task automatic word_done(input rsp_word_t got);
    rx_cnt++;
    if (ovf_mode) check_rsp(got, ovf_word);
    else if (exp_q.size() == 0) note_failure("response word arrived with none expected");
    else check_rsp(got, exp_q.pop_front());
  endtask

  // Request strobes and error pulses
  always @(negedge clk) begin
    if (rst_n) begin
      if (pld_req.read || pld_req.write) pld_seen.push_back(pld_req);
      if (ehip_req.read || ehip_req.write) ehip_seen.push_back(ehip_req);
      if (error) err_pulses++;
    end
  end

  // Serial decoder, a word starts on a 1 while idle
  always @(negedge clk) begin
    if (rst_n && (rx_idx != 0 || data_out === 1'b1)) begin
      rx_bits[rx_idx] = data_out;
      rx_idx = rx_idx + 1;
      if (rx_idx == 16) begin
        rx_idx = 0;
        word_done(rx_bits);
      end
    end
  end

  task automatic send_frame(input logic [31:0] w);
    tick();
    data_in = 2'd3;                  // Start symbol
    for (int i = 0; i < 16; i++) begin
      tick();
      data_in = w[2*i +: 2];
    end
    tick();
    data_in = 2'd0;
  endtask

  task automatic wait_cmd_result(input int e0);
    int t;
    t = 0;
    while (pld_seen.size() == 0 && ehip_seen.size() == 0 && err_pulses == e0 && t < 20) begin
      tick();
      t++;
    end
    if (t >= 20) report_timeout("a request strobe or an error pulse");
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < 600) begin
      tick();
      t++;
    end
    if (exp_q.size() != 0) report_timeout("the expected response words");
  endtask

  // Commands in one mode, each answered by the target model
  task automatic run_cmds(input logic sel, input int n);
    logic [31:0] r;
    logic        rd;
    logic [20:0] addr;
    logic [7:0]  dat;
    logic [7:0]  rdat;
    logic [2:0]  rsv;
    int          e0;
    tick();
    hip_sel = sel;
    for (int i = 0; i < n && !hung; i++) begin
      r    = next_rand();
      rd   = r[0];
      addr = sel ? r[21:1] : {12'd0, r[9:1]};
      dat  = r[31:24];
      e0   = err_pulses;
      send_frame(make_cmd(sel, rd, ~rd, addr, dat));
      wait_cmd_result(e0);
      if (err_pulses != e0) note_failure("error pulse on a valid command");
      if (sel && ehip_seen.size() == 1 && pld_seen.size() == 0) begin
        check_ehip_req(ehip_seen.pop_front(), '{read: rd, write: ~rd, addr: addr, wdata: dat});
      end else if (!sel && pld_seen.size() == 1 && ehip_seen.size() == 0) begin
        check_pld_req(pld_seen.pop_front(),
                      '{read: rd, write: ~rd, reg_addr: addr[8:0], writedata: dat});
      end else begin
        note_failure("wrong number of request strobes");
      end
      pld_seen.delete();
      ehip_seen.delete();
      r    = next_rand();
      rdat = r[7:0];
      rsv  = r[10:8];
      repeat (1 + r[13:12]) tick();  // Target latency
      if (sel && rd) begin
        ehip_rsp.rdatavld = 1'b1;
        ehip_rsp.rdata    = rdat;
        exp_q.push_back(exp_word(1'b0, rdat, 1'b1, 3'b101));
      end else if (sel) begin
        ehip_rsp.wrdone = 1'b1;
        exp_q.push_back(exp_word(1'b1, 8'd0, 1'b0, 3'b101));
      end else if (rd) begin
        pld_rsp.readdatavalid = 1'b1;
        pld_rsp.readdata      = rdat;
        pld_rsp.reserved_in   = rsv;
        exp_q.push_back(exp_word(1'b0, rdat, 1'b1, rsv));
      end
      tick();
      pld_rsp  = '0;
      ehip_rsp = '0;
    end
    if (!hung) wait_drain();
  endtask

  task automatic run_busy();
    tick();
    hip_sel = 1'b0;
    for (int i = 0; i < 4; i++) begin
      repeat (2 + next_rand() % 6) tick();
      pld_rsp.busy = ~pld_rsp.busy;
      exp_q.push_back(exp_word(pld_rsp.busy, 8'd0, 1'b0, 3'd0));
    end
    wait_drain();
  endtask

  // Bad parity or read with write, in both modes
  task automatic run_reject();
    logic [31:0] w;
    logic        sel;
    int          e0;
    for (int i = 0; i < 4 && !hung; i++) begin
      sel = i[1];
      tick();
      hip_sel = sel;
      w = next_rand();
      if (i[0]) begin
        w = make_cmd(sel, 1'b1, 1'b1, w[20:0], w[31:24]);
      end else begin
        w = make_cmd(sel, 1'b1, 1'b0, w[20:0], w[31:24]);
        w[31] = ~w[31];
      end
      e0 = err_pulses;
      send_frame(w);
      wait_cmd_result(e0);
      if (pld_seen.size() != 0 || ehip_seen.size() != 0) begin
        note_failure("rejected frame strobed a target");
      end else if (err_pulses == e0 && !hung) begin
        note_failure("rejected frame raised no error");
      end
      pld_seen.delete();
      ehip_seen.delete();
    end
    tick();
    hip_sel = 1'b0;
  endtask

  task automatic run_overflow();
    int n0;
    int e0;
    int t;
    tick();
    hip_sel  = 1'b1;
    ovf_word = exp_word(1'b1, 8'd0, 1'b0, 3'b101);
    ovf_mode = 1'b1;
    n0 = rx_cnt;
    e0 = err_pulses;
    ehip_rsp.wrdone = 1'b1;
    repeat (40) tick();
    ehip_rsp.wrdone = 1'b0;
    if (!ungate) note_failure("clock ungate low with responses queued");
    t = 0;
    while ((ungate || data_out || rx_idx != 0) && t < 1000) begin
      tick();
      t++;
    end
    if (t >= 1000) report_timeout("the response line to go idle");
    if (err_pulses == e0) note_failure("no error pulse on FIFO overflow");
    if (rx_cnt == n0 || rx_cnt - n0 > 40) note_failure("response word count out of range");
    ovf_mode = 1'b0;
    hip_sel  = 1'b0;
  endtask

  task automatic report_test(input string name, input int e0);
    $display("Test %s: %s", name, (errors == e0) ? "ok" : "failed");
  endtask

  initial begin
    int e0;
    rng        = 32'd24;
    rst_n      = 1'b0;
    data_in    = 2'd0;
    hip_sel    = 1'b0;
    pld_rsp    = '0;
    ehip_rsp   = '0;
    checks     = 0;
    errors     = 0;
    err_pulses = 0;
    rx_cnt     = 0;
    rx_idx     = 0;
    hung       = 1'b0;
    ovf_mode   = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    tick();
    if (data_out || ungate || error) note_failure("outputs not idle after reset");
    if (pld_req.read || pld_req.write || ehip_req.read || ehip_req.write) begin
      note_failure("request strobe high after reset");
    end
    e0 = errors;
    run_cmds(1'b0, 12);
    report_test("pld_cmd", e0);
    if (!hung) begin
      e0 = errors;
      run_cmds(1'b1, 12);
      report_test("ehip_cmd", e0);
    end
    if (!hung) begin
      e0 = errors;
      run_busy();
      report_test("busy", e0);
    end
    if (!hung) begin
      e0 = errors;
      run_reject();
      report_test("reject", e0);
    end
    if (!hung) begin
      e0 = errors;
      run_overflow();
      report_test("overflow", e0);
    end
    $display("Checks %0d, errors %0d, response words %0d", checks, errors, rx_cnt);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/avmm_transfer.sv */
// Top level of the AVMM transfer block: command builder, response packer,
// response FIFO and serializer on one clock.
`timescale 1ns/100ps
`default_nettype none

module avmm_transfer #(
  parameter int FIFO_AWIDTH = 4
) (
  input  wire logic                     avmm_clock_avmm_clk,
  input  wire logic                     avmm_reset_avmm_rst_n,
  input  wire logic [1:0]               aib_hssi_avmm_data_in,
  input  wire logic                     r_avmm2_hip_sel,
  input  wire avmm_rsp_pkg::pld_rsp_t   pld_rsp,
  input  wire avmm_rsp_pkg::ehip_rsp_t  ehip_rsp,
  output avmm_cmd_pkg::pld_req_t        pld_req,
  output avmm_cmd_pkg::ehip_req_t       ehip_req,
  output logic                          aib_hssi_avmm_data_out,
  output logic                          avmm_transfer_dcg_ungate,
  output logic                          avmm_transfer_error
);
  import avmm_rsp_pkg::*;

  logic      frame_active;
  logic      cmd_error;
  logic      rsp_wr_en;
  rsp_word_t rsp_wr_word;
  logic      fifo_rd_en;
  rsp_word_t fifo_rd_word;
  logic      fifo_empty;
  logic      fifo_overflow;
  logic      ser_busy;

  avmm_cmd_builder avmm_cmd_builder_i (
    .avmm_clock_avmm_clk   (avmm_clock_avmm_clk),
    .avmm_reset_avmm_rst_n (avmm_reset_avmm_rst_n),
    .aib_hssi_avmm_data_in (aib_hssi_avmm_data_in),
    .hip_sel               (r_avmm2_hip_sel),
    .pld_req               (pld_req),
    .ehip_req              (ehip_req),
    .frame_active          (frame_active),
    .error                 (cmd_error)
  );

  avmm_rsp_packer avmm_rsp_packer_i (
    .avmm_clock_avmm_clk   (avmm_clock_avmm_clk),
    .avmm_reset_avmm_rst_n (avmm_reset_avmm_rst_n),
    .hip_sel               (r_avmm2_hip_sel),
    .pld_rsp               (pld_rsp),
    .ehip_rsp              (ehip_rsp),
    .wr_en                 (rsp_wr_en),
    .wr_word               (rsp_wr_word)
  );

  avmm_rsp_fifo #(
    .FIFO_AWIDTH (FIFO_AWIDTH)
  ) avmm_rsp_fifo_i (
    .avmm_clock_avmm_clk   (avmm_clock_avmm_clk),
    .avmm_reset_avmm_rst_n (avmm_reset_avmm_rst_n),
    .wr_en                 (rsp_wr_en),
    .wr_word               (rsp_wr_word),
    .rd_en                 (fifo_rd_en),
    .rd_word               (fifo_rd_word),
    .empty                 (fifo_empty),
    .overflow              (fifo_overflow)
  );

  avmm_rsp_serializer avmm_rsp_serializer_i (
    .avmm_clock_avmm_clk   (avmm_clock_avmm_clk),
    .avmm_reset_avmm_rst_n (avmm_reset_avmm_rst_n),
    .empty                 (fifo_empty),
    .rd_word               (fifo_rd_word),
    .rd_en                 (fifo_rd_en),
    .data_out              (aib_hssi_avmm_data_out),
    .busy                  (ser_busy)
  );

  assign avmm_transfer_error      = cmd_error | fifo_overflow;
  // Clock must run while any part of the path holds work
  assign avmm_transfer_dcg_ungate = frame_active | ~fifo_empty | ser_busy;

endmodule

`default_nettype wire

/* hw/avmm_rsp_serializer.sv */
// Pops response words from the FIFO and sends them LSB first, one bit
// per clock, from a registered output; the line rests at 0.
`timescale 1ns/100ps
`default_nettype none

module avmm_rsp_serializer (
  input  wire logic                     avmm_clock_avmm_clk,
  input  wire logic                     avmm_reset_avmm_rst_n,
  input  wire logic                     empty,
  input  wire avmm_rsp_pkg::rsp_word_t  rd_word,
  output logic                          rd_en,
  output logic                          data_out,
  output logic                          busy
);
  import avmm_rsp_pkg::*;

  localparam int CNT_W = $clog2(RSP_BITS);

  logic [CNT_W-1:0]    bit_cnt;    // Index of the bit now on data_out
  logic [RSP_BITS-2:0] shift_q;
  logic                last_bit;

  assign last_bit = busy && (bit_cnt == CNT_W'(RSP_BITS - 1));
  assign rd_en    = !empty && (!busy || last_bit);   // Back to back on the last bit

  always_ff @(posedge avmm_clock_avmm_clk) begin
    if (!avmm_reset_avmm_rst_n) begin
      busy     <= 1'b0;
      bit_cnt  <= '0;
      data_out <= 1'b0;
    end else if (rd_en) begin
      busy     <= 1'b1;
      bit_cnt  <= '0;
      data_out <= rd_word[0];
    end else if (last_bit) begin
      busy     <= 1'b0;
      data_out <= 1'b0;
    end else if (busy) begin
      bit_cnt  <= bit_cnt + 1'b1;
      data_out <= shift_q[0];
    end
  end

  always_ff @(posedge avmm_clock_avmm_clk) begin
    if (rd_en) shift_q <= rd_word[RSP_BITS-1:1];
    else       shift_q <= shift_q >> 1;
  end

endmodule

`default_nettype wire

/* hw/avmm_rsp_fifo.sv */
// Single-clock response FIFO with wrap-bit pointers; writes into a full
// FIFO are dropped and flagged on overflow.
`timescale 1ns/100ps
`default_nettype none

module avmm_rsp_fifo #(
  parameter int FIFO_AWIDTH = 4
) (
  input  wire logic                     avmm_clock_avmm_clk,
  input  wire logic                     avmm_reset_avmm_rst_n,
  input  wire logic                     wr_en,
  input  wire avmm_rsp_pkg::rsp_word_t  wr_word,
  input  wire logic                     rd_en,
  output avmm_rsp_pkg::rsp_word_t       rd_word,
  output logic                          empty,
  output logic                          overflow
);
  import avmm_rsp_pkg::*;

  localparam logic [FIFO_AWIDTH:0] DEPTH = 1 << FIFO_AWIDTH;

  rsp_word_t              mem [0:DEPTH-1];
  logic [FIFO_AWIDTH:0]   wr_ptr;
  logic [FIFO_AWIDTH:0]   rd_ptr;
  logic [FIFO_AWIDTH:0]   level;
  logic                   full;

  assign level   = wr_ptr - rd_ptr;                 // Wrap bit keeps full apart from empty
  assign empty   = (wr_ptr == rd_ptr);
  assign full    = (level == DEPTH);
  assign rd_word = mem[rd_ptr[FIFO_AWIDTH-1:0]];    // Head word, valid before the pop

  always_ff @(posedge avmm_clock_avmm_clk) begin
    if (wr_en && !full) mem[wr_ptr[FIFO_AWIDTH-1:0]] <= wr_word;
  end

  always_ff @(posedge avmm_clock_avmm_clk) begin
    if (!avmm_reset_avmm_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en && !full) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en && !empty) rd_ptr <= rd_ptr + 1'b1;
      overflow <= wr_en & full;                      // Word is lost
    end
  end

  // Serializer only pops a word it can see
  a_no_pop_empty: assert property (@(posedge avmm_clock_avmm_clk)
    disable iff (!avmm_reset_avmm_rst_n) rd_en |-> !empty);

  a_level_bound: assert property (@(posedge avmm_clock_avmm_clk)
    disable iff (!avmm_reset_avmm_rst_n) level <= DEPTH);

endmodule

`default_nettype wire

/* hw/avmm_rsp_packer.sv */
// Turns target response events into parity-protected response words
// for the response FIFO, in the same cycle as the event.
`timescale 1ns/100ps
`default_nettype none

module avmm_rsp_packer (
  input  wire logic                    avmm_clock_avmm_clk,
  input  wire logic                    avmm_reset_avmm_rst_n,
  input  wire logic                    hip_sel,
  input  wire avmm_rsp_pkg::pld_rsp_t  pld_rsp,
  input  wire avmm_rsp_pkg::ehip_rsp_t ehip_rsp,
  output logic                         wr_en,
  output avmm_rsp_pkg::rsp_word_t      wr_word
);
  import avmm_rsp_pkg::*;

  logic       busy_int;
  logic       busy_q;
  logic       busy_chg;
  logic       rdv;
  logic       status;
  logic [7:0] rdata;
  logic [2:0] rsvd;
  logic       rsp_parity;

  assign busy_int = hip_sel ? 1'b0 : pld_rsp.busy;   // No busy level from EHIP

  always_ff @(posedge avmm_clock_avmm_clk) begin
    if (!avmm_reset_avmm_rst_n) busy_q <= 1'b0;
    else                        busy_q <= busy_int;
  end

  assign busy_chg = (busy_q != busy_int);
  assign rdv      = hip_sel ? ehip_rsp.rdatavld : pld_rsp.readdatavalid;
  assign wr_en    = rdv | busy_chg | ehip_rsp.wrdone;

  // Source select for the word fields
  assign status = hip_sel ? ehip_rsp.wrdone : busy_int;
  assign rdata  = hip_sel ? ehip_rsp.rdata  : pld_rsp.readdata;
  assign rsvd   = hip_sel ? EHIP_RSVD       : pld_rsp.reserved_in;

  // Even parity over the other 15 bits, two marker bits included
  assign rsp_parity = ^{1'b1, rsvd, rdv, rdata, status, 1'b1};

  always_comb begin
    wr_word.sym0 = {status, 1'b1};
    wr_word.sym1 = rdata[1:0];
    wr_word.sym2 = rdata[3:2];
    wr_word.sym3 = rdata[5:4];
    wr_word.sym4 = rdata[7:6];
    wr_word.sym5 = {rsvd[0], rdv};
    wr_word.sym6 = rsvd[2:1];
    wr_word.sym7 = {1'b1, rsp_parity};
  end

endmodule

`default_nettype wire

/* hw/avmm_cmd_builder.sv */
// Collects 2-bit command symbols into a 32-bit frame, checks it and
// strobes the remote PLD or the EHIP port as chosen by hip_sel.
`timescale 1ns/100ps
`default_nettype none

module avmm_cmd_builder (
  input  wire logic                    avmm_clock_avmm_clk,
  input  wire logic                    avmm_reset_avmm_rst_n,
  input  wire logic [1:0]              aib_hssi_avmm_data_in,
  input  wire logic                    hip_sel,
  output avmm_cmd_pkg::pld_req_t       pld_req,
  output avmm_cmd_pkg::ehip_req_t      ehip_req,
  output logic                         frame_active,
  output logic                         error
);
  import avmm_cmd_pkg::*;

  localparam int CNT_W = $clog2(CMD_SYMBOLS);

  typedef enum logic {
    ST_IDLE,
    ST_COLLECT
  } state_t;

  state_t                     state;
  logic [CNT_W-1:0]           sym_cnt;
  logic [2*CMD_SYMBOLS-1:0]   shift_q;
  cmd_word_u                  word;
  logic                       last_sym;
  logic                       rw_clash;
  logic                       cmd_ok;

  // New symbols enter at the top, so the first one ends at bits 1:0
  assign word = {aib_hssi_avmm_data_in, shift_q[2*CMD_SYMBOLS-1:2]};

  assign frame_active = (state == ST_COLLECT);
  assign last_sym     = frame_active && (sym_cnt == CNT_W'(CMD_SYMBOLS - 1));
  assign rw_clash     = hip_sel ? (word.ehip.read & word.ehip.write)
                                : (word.pld.read & word.pld.write);
  assign cmd_ok       = (^word) & ~rw_clash;     // Odd parity in both views

  always_ff @(posedge avmm_clock_avmm_clk) begin
    if (!avmm_reset_avmm_rst_n) begin
      state   <= ST_IDLE;
      sym_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (aib_hssi_avmm_data_in == CMD_START) begin
            state   <= ST_COLLECT;
            sym_cnt <= '0;
          end
        end
        ST_COLLECT: begin
          sym_cnt <= sym_cnt + 1'b1;
          if (last_sym) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge avmm_clock_avmm_clk) begin
    if (frame_active) shift_q <= word;
  end

  // Strobes last one cycle, address and data hold until the next command
  always_ff @(posedge avmm_clock_avmm_clk) begin
    if (!avmm_reset_avmm_rst_n) begin
      pld_req  <= '0;
      ehip_req <= '0;
      error    <= 1'b0;
    end else begin
      pld_req.read   <= 1'b0;
      pld_req.write  <= 1'b0;
      ehip_req.read  <= 1'b0;
      ehip_req.write <= 1'b0;
      error          <= last_sym & ~cmd_ok;
      if (last_sym && cmd_ok) begin
        if (hip_sel) begin
          ehip_req.read  <= word.ehip.read;
          ehip_req.write <= word.ehip.write;
          ehip_req.addr  <= word.ehip.addr;
          ehip_req.wdata <= word.ehip.wdata;
        end else begin
          pld_req.read      <= word.pld.read;
          pld_req.write     <= word.pld.write;
          pld_req.reg_addr  <= word.pld.reg_addr;
          pld_req.writedata <= word.pld.writedata;
        end
      end
    end
  end

  a_one_target: assert property (@(posedge avmm_clock_avmm_clk)
    disable iff (!avmm_reset_avmm_rst_n)
    !((pld_req.read | pld_req.write) && (ehip_req.read | ehip_req.write)));

endmodule

`default_nettype wire

/* hw/avmm_rsp_pkg.sv */
// Response side types: target response buses and the 16-bit serial response word.
`default_nettype none

package avmm_rsp_pkg;

  localparam int RSP_BITS = 16;                 // Serial bits per response word
  localparam logic [2:0] EHIP_RSVD = 3'b101;    // Reserved field in EHIP mode

  typedef struct packed {
    logic       busy;              // Level, a change makes a response
    logic [7:0] readdata;
    logic       readdatavalid;     // One-cycle strobe
    logic [2:0] reserved_in;
  } pld_rsp_t;

  typedef struct packed {
    logic       wrdone;            // One-cycle strobe
    logic [7:0] rdata;
    logic       rdatavld;          // One-cycle strobe
  } ehip_rsp_t;

  // Eight 2-bit symbols, sym0 goes out first
  typedef struct packed {
    logic [1:0] sym7;              // {1, even parity}
    logic [1:0] sym6;              // Reserved bits 2:1
    logic [1:0] sym5;              // {reserved bit 0, data valid}
    logic [1:0] sym4;
    logic [1:0] sym3;
    logic [1:0] sym2;
    logic [1:0] sym1;              // Read data bits 1:0
    logic [1:0] sym0;              // {status, 1}
  } rsp_word_t;

endpackage

`default_nettype wire

/* hw/avmm_cmd_pkg.sv */
// Command side types for the AVMM transfer block.
// Frame layout, the dual-view command word and the target request buses.
`default_nettype none

package avmm_cmd_pkg;

  localparam int CMD_SYMBOLS = 16;            // Data symbols per frame
  localparam logic [1:0] CMD_START = 2'd3;    // Frame start, only seen while idle

  // Remote PLD view, bit 0 is write
  typedef struct packed {
    logic        parity;       // Odd parity over the whole word
    logic [11:0] reserved;
    logic [7:0]  writedata;
    logic [8:0]  reg_addr;
    logic        read;
    logic        write;
  } pld_cmd_t;

  // EHIP view, bit 0 is wdata[0]
  typedef struct packed {
    logic        parity;
    logic        read;
    logic        write;
    logic [20:0] addr;
    logic [7:0]  wdata;
  } ehip_cmd_t;

  // Same received word, decoded per hip_sel
  typedef union packed {
    pld_cmd_t  pld;
    ehip_cmd_t ehip;
  } cmd_word_u;

  typedef struct packed {
    logic       read;          // One-cycle strobe
    logic       write;         // One-cycle strobe
    logic [8:0] reg_addr;
    logic [7:0] writedata;
  } pld_req_t;

  typedef struct packed {
    logic        read;
    logic        write;
    logic [20:0] addr;
    logic [7:0]  wdata;
  } ehip_req_t;

endpackage

`default_nettype wire
